// File: Makefile
# Verilator build and run for the FIR filter testbench

VERILATOR ?= verilator
TOP       ?= tb_fir
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: hw/fir_adder_tree.sv
// Registered adder tree of the FIR filter.
// Reduces the weighted pairs 12 -> 6 -> 3 -> 2 -> 1, one level per
// enabled clock, with a pass-through register for the odd word.
`timescale 1ns/1ps
`default_nettype none

module fir_adder_tree #(
	parameter int DATA_WIDTH = fir_pkg::DATA_WIDTH
) (
	input  wire logic                         clk,
	input  wire logic                         reset,
	input  wire logic                         i_clk_ena,
	input  wire logic signed [DATA_WIDTH-1:0] i_products [fir_pkg::NUM_UNIQ],
	output logic signed [DATA_WIDTH-1:0]      o_sum
);

	import fir_pkg::*;

	localparam int L1_N = NUM_UNIQ / 2;
	localparam int L2_N = L1_N / 2;

	logic signed [DATA_WIDTH-1:0] lvl1_q [L1_N];
	logic signed [DATA_WIDTH-1:0] lvl2_q [L2_N];
	logic signed [DATA_WIDTH-1:0] lvl3_sum_q;
	// bye register, keeps the odd level 2 word in step
	logic signed [DATA_WIDTH-1:0] lvl3_bye_q;

	// ************************************************************************
	// levels 1 and 2
	// ************************************************************************

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int k = 0; k < L1_N; k++) begin
				lvl1_q[k] <= '0;
			end
			for (int k = 0; k < L2_N; k++) begin
				lvl2_q[k] <= '0;
			end
		end else if (i_clk_ena) begin
			// neighbouring products pair up
			for (int k = 0; k < L1_N; k++) begin
				lvl1_q[k] <= i_products[2*k] + i_products[2*k+1];
			end
			for (int k = 0; k < L2_N; k++) begin
				lvl2_q[k] <= lvl1_q[2*k] + lvl1_q[2*k+1];
			end
		end
	end

	// ************************************************************************
	// levels 3 and 4
	// ************************************************************************

	// three words left, so one add and one bye
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			lvl3_sum_q <= '0;
			lvl3_bye_q <= '0;
			o_sum      <= '0;
		end else if (i_clk_ena) begin
			lvl3_sum_q <= lvl2_q[0] + lvl2_q[1];
			lvl3_bye_q <= lvl2_q[2];
			o_sum      <= lvl3_sum_q + lvl3_bye_q;
		end
	end

	// ************************************************************************
	// checks
	// ************************************************************************

	// anything unknown here came from upstream, taps or products
	a_sum_known : assert property (
		@(posedge clk) disable iff (reset)
		!$isunknown(o_sum)
	) else $error("filter output is unknown");

endmodule

`default_nettype wire

// File: hw/fir_pkg.sv
// Shared constants and types for the 24-tap symmetric FIR filter.
// Holds the word width, tap counts, pipeline latency and the fixed
// table of unique coefficients.
`default_nettype none

package fir_pkg;

	// ************************************************************************
	// widths and sizes
	// ************************************************************************

	// sample, partial sum and output width
	localparam int DATA_WIDTH = 18;

	localparam int NUM_TAPS = 24;

	// symmetric filter, so only half the coefficients are unique
	localparam int NUM_UNIQ = NUM_TAPS / 2;

	// enabled edges from sample capture to registered output
	// tap, pre-sum, product, then four adder tree levels
	localparam int PIPE_LATENCY = 7;

	typedef logic signed [DATA_WIDTH-1:0] sample_t;

	// ************************************************************************
	// coefficient table
	// ************************************************************************

	// entry k weights the pair tap k + tap (NUM_TAPS-1-k)
	localparam logic signed [17:0] COEFFS [NUM_UNIQ] = '{
		18'sd88,
		18'sd0,
		-18'sd97,
		-18'sd197,
		-18'sd294,
		-18'sd380,
		-18'sd447,
		-18'sd490,
		-18'sd504,
		-18'sd481,
		-18'sd420,
		-18'sd319
	};

endpackage

`default_nettype wire

// File: hw/fir_preadd_mult.sv
// Pre-adders and coefficient multipliers of the symmetric FIR.
// Mirrored taps are summed into one register rank, and each sum is
// weighted by its coefficient into a second rank. Both ranks keep
// only the low DATA_WIDTH bits.
`timescale 1ns/1ps
`default_nettype none

module fir_preadd_mult #(
	parameter int DATA_WIDTH = fir_pkg::DATA_WIDTH
) (
	input  wire logic                         clk,
	input  wire logic                         reset,
	input  wire logic                         i_clk_ena,
	input  wire logic signed [DATA_WIDTH-1:0] i_taps [fir_pkg::NUM_TAPS],
	output logic signed [DATA_WIDTH-1:0]      o_products [fir_pkg::NUM_UNIQ]
);

	import fir_pkg::*;

	logic signed [DATA_WIDTH-1:0] coeff [NUM_UNIQ];
	logic signed [DATA_WIDTH-1:0] pre_sum_q [NUM_UNIQ];

	// table entries resized to the datapath width
	for (genvar g = 0; g < NUM_UNIQ; g++) begin : g_coeff
		assign coeff[g] = DATA_WIDTH'(COEFFS[g]);
	end

	// ************************************************************************
	// pre-adder rank
	// ************************************************************************

	// tap k pairs with tap NUM_TAPS-1-k, sum wraps
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int k = 0; k < NUM_UNIQ; k++) begin
				pre_sum_q[k] <= '0;
			end
		end else if (i_clk_ena) begin
			for (int k = 0; k < NUM_UNIQ; k++) begin
				pre_sum_q[k] <= i_taps[k] + i_taps[NUM_TAPS-1-k];
			end
		end
	end

	// ************************************************************************
	// multiplier rank
	// ************************************************************************

	// only the low bits of each product are kept
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int k = 0; k < NUM_UNIQ; k++) begin
				o_products[k] <= '0;
			end
		end else if (i_clk_ena) begin
			for (int k = 0; k < NUM_UNIQ; k++) begin
				o_products[k] <= pre_sum_q[k] * coeff[k];
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/fir_tap_line.sv
// Sample delay line of the FIR filter.
// Shifts a new sample into tap 0 on every enabled clock.
`timescale 1ns/1ps
`default_nettype none

module fir_tap_line #(
	parameter int DATA_WIDTH = fir_pkg::DATA_WIDTH
) (
	input  wire logic                         clk,
	input  wire logic                         reset,
	input  wire logic                         i_clk_ena,
	input  wire logic signed [DATA_WIDTH-1:0] i_in,
	output logic signed [DATA_WIDTH-1:0]      o_taps [fir_pkg::NUM_TAPS]
);

	import fir_pkg::*;

	// tap k holds the sample taken k enabled edges earlier
	logic [NUM_TAPS-1:0][DATA_WIDTH-1:0] tap_q;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			tap_q <= '0;
		end else if (i_clk_ena) begin
			tap_q <= {tap_q[NUM_TAPS-2:0], i_in};
		end
	end

	// unpacked view for the pre-adders
	for (genvar g = 0; g < NUM_TAPS; g++) begin : g_tap_out
		assign o_taps[g] = tap_q[g];
	end

	// ************************************************************************
	// checks
	// ************************************************************************

	// a stalled edge must leave the whole window untouched
	a_hold_on_stall : assert property (
		@(posedge clk) disable iff (reset)
		!i_clk_ena |=> $stable(tap_q)
	) else $error("tap line moved while clock enable was low");

endmodule

`default_nettype wire

// File: hw/fir_top.sv
// Top level of the 24-tap symmetric FIR filter.
// Chains the tap line, pre-adders and multipliers, and the adder tree,
// with the valid strobe delayed alongside.
`timescale 1ns/1ps
`default_nettype none

module fir_top (
	input  wire logic             clk,
	input  wire logic             reset,
	input  wire logic             i_clk_ena,
	input  wire logic             i_valid,
	input  wire fir_pkg::sample_t i_in,
	output logic                  o_valid,
	output fir_pkg::sample_t      o_out
);

	import fir_pkg::*;

	// datapath width follows the sample type
	localparam int DATA_WIDTH = $bits(sample_t);

	// ************************************************************************
	// stage wiring
	// ************************************************************************

	logic signed [DATA_WIDTH-1:0] taps [NUM_TAPS];
	logic signed [DATA_WIDTH-1:0] products [NUM_UNIQ];

	// window of the last NUM_TAPS samples
	fir_tap_line #(
		.DATA_WIDTH (DATA_WIDTH)
	) fir_tap_line_inst (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_in      (i_in),
		.o_taps    (taps)
	);

	// two ranks, pre-sum then product
	fir_preadd_mult #(
		.DATA_WIDTH (DATA_WIDTH)
	) fir_preadd_mult_inst (
		.clk        (clk),
		.reset      (reset),
		.i_clk_ena  (i_clk_ena),
		.i_taps     (taps),
		.o_products (products)
	);

	// four levels, last one is the output register
	fir_adder_tree #(
		.DATA_WIDTH (DATA_WIDTH)
	) fir_adder_tree_inst (
		.clk        (clk),
		.reset      (reset),
		.i_clk_ena  (i_clk_ena),
		.i_products (products),
		.o_sum      (o_out)
	);

	fir_valid_delay fir_valid_delay_inst (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.o_valid   (o_valid)
	);

endmodule

`default_nettype wire

// File: hw/fir_valid_delay.sv
// Valid strobe delay for the FIR filter.
// Carries i_valid through as many enabled stages as the data path.
`timescale 1ns/1ps
`default_nettype none

module fir_valid_delay (
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic i_clk_ena,
	input  wire logic i_valid,
	output logic      o_valid
);

	import fir_pkg::*;

	// bit 0 is taken with the sample going into tap 0
	logic [PIPE_LATENCY-1:0] valid_q;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_q <= '0;
		end else if (i_clk_ena) begin
			valid_q <= {valid_q[PIPE_LATENCY-2:0], i_valid};
		end
	end

	assign o_valid = valid_q[PIPE_LATENCY-1];

	// ************************************************************************
	// checks
	// ************************************************************************

	// nothing may look valid right as reset lets go
	a_quiet_after_reset : assert property (
		@(posedge clk)
		$fell(reset) |-> !o_valid
	) else $error("o_valid high in the first cycle after reset");

endmodule

`default_nettype wire

// File: src.f
hw/fir_pkg.sv
hw/fir_tap_line.sv
hw/fir_preadd_mult.sv
hw/fir_adder_tree.sv
hw/fir_valid_delay.sv
hw/fir_top.sv
tb/tb_fir.sv

// File: tb/tb_fir.sv
// Testbench for the 24-tap symmetric FIR filter.
// Applies a table of stimulus entries and compares o_out and o_valid
// with a model built on the filter's arithmetic rule.
`timescale 1ns/1ps
`default_nettype none

module tb_fir;

	import fir_pkg::*;

	// table row whose sample is drawn at apply time when rnd is set
	typedef struct packed {
		logic    ena;
		logic    valid;
		logic    rnd;
		logic    has_exp;
		sample_t sample;
		sample_t exp_out;
	} entry_t;

	// model result waiting for its turn at the output
	typedef struct packed {
		logic    valid;
		logic    has_exp;
		sample_t exp_tbl;
		sample_t model_out;
	} pipe_t;

	// first half of the impulse response
	localparam sample_t IMPULSE_HALF [NUM_UNIQ] = '{
		18'sd88, 18'sd0, -18'sd97, -18'sd197, -18'sd294, -18'sd380,
		-18'sd447, -18'sd490, -18'sd504, -18'sd481, -18'sd420, -18'sd319
	};

	logic    clk = 1'b0;
	logic    reset;
	logic    i_clk_ena;
	logic    i_valid;
	sample_t i_in;
	logic    o_valid;
	sample_t o_out;

	entry_t      table_q [$];
	pipe_t       pipe_q [$];
	pipe_t       cur = '0;
	logic        fresh = 1'b0;
	sample_t     history [NUM_TAPS];
	logic [31:0] lfsr_state = 32'h846b;
	int          err_out = 0;
	int          err_valid = 0;
	int          err_other = 0;
	int          impulse_seen = 0;
	int          cycle_count = 0;
	int          timeout_limit = 1000;

	always #2 clk = ~clk;

	fir_top fir_top_inst (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.i_in      (i_in),
		.o_valid   (o_valid),
		.o_out     (o_out)
	);

	// ************************************************************************
	// random samples
	// ************************************************************************

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic draw_sample(output sample_t s);
		s = '0;
		for (int b = 0; b < DATA_WIDTH; b++) begin
			lfsr_state = lfsr_step(lfsr_state);
			s = {s[DATA_WIDTH-2:0], lfsr_state[0]};
		end
	endtask

	// ************************************************************************
	// stimulus table
	// ************************************************************************

	task automatic add_entry(input logic ena, input logic valid, input logic rnd,
			input sample_t sample, input logic has_exp, input sample_t exp_out);
		entry_t e;
		e.ena = ena;
		e.valid = valid;
		e.rnd = rnd;
		e.has_exp = has_exp;
		e.sample = sample;
		e.exp_out = exp_out;
		table_q.push_back(e);
	endtask

	task automatic build_table();
		sample_t first;
		// quiet pipeline after reset
		repeat (10) add_entry(1'b1, 1'b0, 1'b0, '0, 1'b0, '0);
		// impulse where each window carries its expected output
		for (int j = 0; j < NUM_TAPS; j++) begin
			first = '0;
			if (j == 0) begin
				first = 18'sd1;
			end
			if (j < NUM_UNIQ) begin
				add_entry(1'b1, 1'b1, 1'b0, first, 1'b1, IMPULSE_HALF[j]);
			end else begin
				add_entry(1'b1, 1'b1, 1'b0, first, 1'b1, IMPULSE_HALF[NUM_TAPS-1-j]);
			end
		end
		repeat (4) add_entry(1'b1, 1'b1, 1'b0, '0, 1'b0, '0);
		// random stream
		repeat (30) add_entry(1'b1, 1'b1, 1'b1, '0, 1'b0, '0);
		// clock enable gaps inside the stream
		repeat (5) add_entry(1'b0, 1'b1, 1'b1, '0, 1'b0, '0);
		repeat (20) add_entry(1'b1, 1'b1, 1'b1, '0, 1'b0, '0);
		add_entry(1'b0, 1'b1, 1'b1, '0, 1'b0, '0);
		repeat (10) add_entry(1'b1, 1'b1, 1'b1, '0, 1'b0, '0);
		// valid gaps where samples still shift in
		repeat (3) add_entry(1'b1, 1'b0, 1'b1, '0, 1'b0, '0);
		repeat (12) add_entry(1'b1, 1'b1, 1'b1, '0, 1'b0, '0);
		// valid gap with a stall in it
		repeat (2) add_entry(1'b1, 1'b0, 1'b1, '0, 1'b0, '0);
		repeat (2) add_entry(1'b0, 1'b0, 1'b1, '0, 1'b0, '0);
		add_entry(1'b1, 1'b0, 1'b1, '0, 1'b0, '0);
		repeat (12) add_entry(1'b1, 1'b1, 1'b1, '0, 1'b0, '0);
		// drain
		repeat (PIPE_LATENCY + 3) add_entry(1'b1, 1'b0, 1'b0, '0, 1'b0, '0);
	endtask

	// ************************************************************************
	// model
	// ************************************************************************

	// y = sum of coeff k times (x[n-k] + x[n-23+k])
	function automatic sample_t window_output();
		longint acc;
		acc = '0;
		for (int k = 0; k < NUM_UNIQ; k++) begin
			acc += (longint'(history[k]) + longint'(history[NUM_TAPS-1-k]))
				* longint'(COEFFS[k]);
		end
		// wrapping once at the end equals wrapping at every stage
		return sample_t'(acc);
	endfunction

	// called on the edge where the DUT takes entry e
	task automatic model_step(input entry_t e);
		pipe_t r;
		fresh = 1'b0;
		if (e.ena) begin
			for (int k = NUM_TAPS - 1; k > 0; k--) begin
				history[k] = history[k-1];
			end
			history[0] = e.sample;
			r.model_out = window_output();
			r.valid = e.valid;
			r.has_exp = e.has_exp;
			r.exp_tbl = e.exp_out;
			pipe_q.push_back(r);
			cur = pipe_q.pop_front();
			fresh = 1'b1;
		end
	endtask

	// ************************************************************************
	// checks
	// ************************************************************************

	task automatic check_sample(input string name, input sample_t exp, input sample_t got);
		if (got !== exp) begin
			err_out++;
			$display("Mismatch %s exp %h got %h at %0t", name, exp, got, $time);
		end
	endtask

	task automatic check_valid(input logic exp, input logic got);
		if (got !== exp) begin
			err_valid++;
			$display("Mismatch o_valid exp %h got %h at %0t", exp, got, $time);
		end
	endtask

	task automatic check_outputs();
		check_valid(cur.valid, o_valid);
		check_sample("o_out", cur.model_out, o_out);
		// impulse words count only where the DUT marks them valid
		if (fresh && o_valid === 1'b1 && cur.has_exp) begin
			impulse_seen++;
			check_sample("o_out", cur.exp_tbl, o_out);
		end
	endtask

	// ************************************************************************
	// run
	// ************************************************************************

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_limit) begin
			$display("run timed out after %0d cycles", cycle_count);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	initial begin
		entry_t  e;
		entry_t  pend;
		sample_t s;
		reset = 1'b1;
		i_clk_ena = 1'b0;
		i_valid = 1'b0;
		i_in = '0;
		pend = '0;
		for (int k = 0; k < NUM_TAPS; k++) begin
			history[k] = '0;
		end
		build_table();
		timeout_limit = table_q.size() + PIPE_LATENCY + 50;
		// output register ranks after reset hold zeros
		for (int k = 0; k < PIPE_LATENCY - 1; k++) begin
			pipe_q.push_back('0);
		end
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < table_q.size(); i++) begin
			e = table_q[i];
			if (e.rnd) begin
				draw_sample(s);
				e.sample = s;
			end
			@(posedge clk);
			model_step(pend);
			i_clk_ena <= e.ena;
			i_valid <= e.valid;
			i_in <= e.sample;
			pend = e;
			@(negedge clk);
			check_outputs();
		end
		if (impulse_seen != NUM_TAPS) begin
			err_other++;
			$display("impulse response seen on %0d of %0d valid outputs",
				impulse_seen, NUM_TAPS);
		end
		$display("errors: o_out %0d, o_valid %0d, other %0d", err_out, err_valid, err_other);
		if (err_out == 0 && err_valid == 0 && err_other == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
